/* project.f */
source/mio_pkg.sv
source/mio_tx_serializer.sv
source/mio_link_pacer.sv
source/mio_rx_deserializer.sv
source/mio_loopback.sv
dv/tb_mio_loopback.sv

/* Bender.yml */
package:
  name: mio_loopback

sources:
  - source/mio_pkg.sv
  - source/mio_tx_serializer.sv
  - source/mio_link_pacer.sv
  - source/mio_rx_deserializer.sv
  - source/mio_loopback.sv
  - target: test
    files:
      - dv/tb_mio_loopback.sv

/* dv/tb_mio_loopback.sv */
`timescale 1ns/1ps

module tb_mio_loopback;

   import mio_pkg::*;

   localparam int npkts          = 200;
   localparam int ncorner        = 5;            // Fixed patterns sent first
   localparam int timeout_cycles = npkts * 80;
   localparam logic [31:0] seed  = 32'hea358280;

   logic          clk = 1'b0;
   logic          rst_n;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_out;
   logic          access_out;
   emesh_packet_t packet_out;
   logic          wait_in;

   logic [31:0]   pkt_rng;                       // Packet data and gaps
   logic [31:0]   stall_rng;                     // wait_in pattern
   int            stall_left;
   logic          burst_phase;                   // No gaps, heavier stalls

   emesh_packet_t expect_q[$];                   // Accepted, not yet delivered
   logic          hold_q;
   emesh_packet_t held_pkt;
   int            n_in;
   int            n_out;
   int            mismatch_errs;
   int            other_errs;
   int            cycle_cnt;

   mio_loopback i_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   always #10 clk = ~clk;                        // 20 ns period

   // ################################################
   // Helpers
   // ################################################

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Zeros, ones, both alternations, then counting bytes
   function automatic emesh_packet_t corner_packet(input int idx);
      logic [pw-1:0] bits;
      bits = '0;
      case (idx)
         0: bits = '0;
         1: bits = '1;
         2: bits = {(pw/2){2'b10}};
         3: bits = {(pw/2){2'b01}};
         default: for (int b = 0; b < nbeats; b++) bits[b*miow +: miow] = miow'(b + 1);
      endcase
      return emesh_packet_t'(bits);
   endfunction

   task automatic random_packet(output emesh_packet_t p);
      logic [127:0] bits;
      for (int k = 0; k < 4; k++) begin
         pkt_rng = xorshift32(pkt_rng);
         bits[k*32 +: 32] = pkt_rng;
      end
      p = emesh_packet_t'(bits[pw-1:0]);
   endtask

   task automatic check_fields(input emesh_packet_t got, input emesh_packet_t exp);
      assert (got.write === exp.write) else begin
         mismatch_errs++;
         $display("Mismatch packet_out.write: got %h, expected %h", got.write, exp.write);
      end
      assert (got.datamode === exp.datamode) else begin
         mismatch_errs++;
         $display("Mismatch packet_out.datamode: got %h, expected %h",
                  got.datamode, exp.datamode);
      end
      assert (got.ctrlmode === exp.ctrlmode) else begin
         mismatch_errs++;
         $display("Mismatch packet_out.ctrlmode: got %h, expected %h",
                  got.ctrlmode, exp.ctrlmode);
      end
      assert (got.dstaddr === exp.dstaddr) else begin
         mismatch_errs++;
         $display("Mismatch packet_out.dstaddr: got %h, expected %h", got.dstaddr, exp.dstaddr);
      end
      assert (got.data === exp.data) else begin
         mismatch_errs++;
         $display("Mismatch packet_out.data: got %h, expected %h", got.data, exp.data);
      end
      assert (got.srcaddr === exp.srcaddr) else begin
         mismatch_errs++;
         $display("Mismatch packet_out.srcaddr: got %h, expected %h", got.srcaddr, exp.srcaddr);
      end
   endtask

   task automatic check_idle_outputs();
      assert (access_out === 1'b0) else begin
         mismatch_errs++;
         $display("Mismatch access_out at reset: got %h, expected 0", access_out);
      end
      assert (wait_out === 1'b0) else begin
         mismatch_errs++;
         $display("Mismatch wait_out at reset: got %h, expected 0", wait_out);
      end
   endtask

   // ################################################
   // Consumer back-pressure
   // ################################################

   always @(posedge clk) begin
      if (!rst_n) begin
         wait_in    <= 1'b0;
         stall_left <= 0;
      end else begin
         stall_rng = xorshift32(stall_rng);
         if (stall_left != 0) begin
            wait_in    <= 1'b1;                  // Long stretch in progress
            stall_left <= stall_left - 1;
         end else if (stall_rng[31:24] < (burst_phase ? 8'd8 : 8'd3)) begin
            wait_in    <= 1'b1;
            stall_left <= 16 + int'(stall_rng[4:0]);
         end else begin
            wait_in <= (stall_rng[15:0] % 10) < 3;   // About 30 percent
         end
      end
   end

   // ################################################
   // Model and checks
   // ################################################

   always @(posedge clk) begin
      if (!rst_n) begin
         hold_q = 1'b0;
      end else begin
         // Output held since last edge must not move
         if (hold_q) begin
            assert (access_out === 1'b1) else begin
               other_errs++;
               $display("access_out dropped while wait_in was holding a packet");
            end
            assert (packet_out === held_pkt) else begin
               mismatch_errs++;
               $display("Mismatch packet_out under wait_in: got %h, expected %h",
                        packet_out, held_pkt);
            end
         end
         hold_q   = (access_out === 1'b1) && (wait_in === 1'b1);
         held_pkt = packet_out;
         if (access_in && !wait_out) begin
            expect_q.push_back(packet_in);       // Accepted this edge
            n_in++;
         end
         if (access_out && !wait_in) begin
            assert (expect_q.size() != 0) else begin
               other_errs++;
               $display("Output packet appeared with no accepted packet outstanding");
            end
            if (expect_q.size() != 0) begin
               check_fields(packet_out, expect_q.pop_front());
               n_out++;
            end
         end
      end
   end

   // Run limit
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == timeout_cycles) begin
         $display("Timeout after %0d cycles, loopback stalled with %0d of %0d packets out",
                  cycle_cnt, n_out, npkts);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // ################################################
   // Stimulus
   // ################################################

   initial begin : stimulus
      emesh_packet_t pkt;
      int            gap;
      rst_n         = 1'b0;
      access_in     = 1'b0;
      packet_in     = '0;
      wait_in       = 1'b0;
      burst_phase   = 1'b0;
      pkt_rng       = seed;
      stall_rng     = xorshift32(seed ^ 32'h9e3779b9);   // Separate stream
      stall_left    = 0;
      n_in          = 0;
      n_out         = 0;
      mismatch_errs = 0;
      other_errs    = 0;
      cycle_cnt     = 0;
      hold_q        = 1'b0;

      for (int k = 0; k < 10; k++) begin
         @(negedge clk);
         check_idle_outputs();
      end
      @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_idle_outputs();                      // Right after release
      @(posedge clk);

      for (int i = 0; i < npkts; i++) begin
         burst_phase <= (i >= 100) && (i < 140);
         pkt_rng = xorshift32(pkt_rng);
         gap     = ((i >= 100) && (i < 140)) ? 0 : int'(pkt_rng[1:0]);
         if (gap != 0) begin
            access_in <= 1'b0;
            repeat (gap) @(posedge clk);
         end
         if (i < ncorner) begin
            pkt = corner_packet(i);
         end else begin
            random_packet(pkt);
         end
         access_in <= 1'b1;
         packet_in <= pkt;
         @(posedge clk);
         while (wait_out) @(posedge clk);     // Taken on this edge
      end
      access_in   <= 1'b0;
      burst_phase <= 1'b0;

      while (n_out < npkts) @(negedge clk);
      repeat (60) @(posedge clk);             // Nothing more may come out

      assert ((n_out == n_in) && (expect_q.size() == 0)) else begin
         other_errs++;
         $display("Accepted %0d packets but delivered %0d", n_in, n_out);
      end
      $display("Errors: %0d mismatches, %0d other; packets in %0d, out %0d",
               mismatch_errs, other_errs, n_in, n_out);
      if ((mismatch_errs == 0) && (other_errs == 0)) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* source/mio_loopback.sv */
`timescale 1ns/1ps

module mio_loopback (
   input  logic                   clk,
   input  logic                   rst_n,
   // Core input
   input  logic                   access_in,
   input  mio_pkg::emesh_packet_t packet_in,
   output logic                   wait_out,
   // Core output
   output logic                   access_out,
   output mio_pkg::emesh_packet_t packet_out,
   input  logic                   wait_in
);

   import mio_pkg::*;

   // ################################################
   // Link wires
   // ################################################

   link_beat_t tx_beat;     // Serializer to pacer
   logic       link_wait;
   link_beat_t rx_beat;     // Pacer to deserializer
   logic       rx_wait;

   mio_tx_serializer i_tx (
      .clk       (clk),
      .rst_n     (rst_n),
      .access_in (access_in),
      .packet_in (packet_in),
      .wait_out  (wait_out),
      .tx_beat   (tx_beat),
      .link_wait (link_wait)
   );

   // Narrow link at IO rate
   mio_link_pacer i_link (
      .clk       (clk),
      .rst_n     (rst_n),
      .tx_beat   (tx_beat),
      .link_wait (link_wait),
      .rx_beat   (rx_beat),
      .rx_wait   (rx_wait)
   );

   mio_rx_deserializer i_rx (
      .clk        (clk),
      .rst_n      (rst_n),
      .rx_beat    (rx_beat),
      .rx_wait    (rx_wait),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

endmodule

/* source/mio_rx_deserializer.sv */
`timescale 1ns/1ps

module mio_rx_deserializer (
   input  logic                   clk,
   input  logic                   rst_n,
   // Link side
   input  mio_pkg::link_beat_t    rx_beat,
   output logic                   rx_wait,
   // Core side
   output logic                   access_out,
   output mio_pkg::emesh_packet_t packet_out,
   input  logic                   wait_in
);

   import mio_pkg::*;

   // ################################################
   // State
   // ################################################

   logic [pw-1:0] shift_q;   // Assembly register, also the output word
   logic [cw-1:0] cnt_q;     // Beats collected
   logic          valid_q;   // Finished packet waiting

   logic last;
   logic consume;

   assign last    = (cnt_q == cw'(nbeats - 1));
   assign consume = valid_q && !wait_in;

   // ################################################
   // Beat collection
   // ################################################

   // New beat enters at the top and moves down
   always_ff @(posedge clk) begin
      if (rx_beat.access) begin
         shift_q <= {rx_beat.data, shift_q[pw-1:miow]};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt_q <= '0;
      end else if (rx_beat.access) begin
         if (last) begin
            cnt_q <= '0;
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   // ################################################
   // Output handshake
   // ################################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else if (rx_beat.access && last) begin
         valid_q <= 1'b1;                               // Thirteenth beat in
      end else if (consume) begin
         valid_q <= 1'b0;
      end
   end

   assign access_out = valid_q;
   assign rx_wait    = valid_q;                         // Freeze pacer while held
   assign packet_out = emesh_packet_t'(shift_q);

   // Held output must not move under back-pressure
   a_hold_out : assert property (
      @(posedge clk) disable iff (!rst_n)
      (access_out && wait_in) |=> (access_out && $stable(packet_out))
   );

   // No beat may land on a packet that is still on the output
   a_no_overrun : assert property (
      @(posedge clk) disable iff (!rst_n)
      valid_q |-> !rx_beat.access
   );

endmodule

/* source/mio_link_pacer.sv */
`timescale 1ns/1ps

module mio_link_pacer (
   input  logic                clk,
   input  logic                rst_n,
   // From serializer
   input  mio_pkg::link_beat_t tx_beat,
   output logic                link_wait,
   // To deserializer
   output mio_pkg::link_beat_t rx_beat,
   input  logic                rx_wait
);

   import mio_pkg::*;

   logic [iow-1:0]  div_q;    // Strobe divider
   logic            strobe;
   logic            full_q;   // Link register occupied
   logic [miow-1:0] data_q;
   logic            take;
   logic            fwd;

   // ################################################
   // IO strobe
   // ################################################

   assign strobe = (div_q == iow'(io_div - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         div_q <= '0;
      end else if (strobe) begin
         div_q <= '0;                                   // Wrap
      end else begin
         div_q <= div_q + 1'b1;
      end
   end

   // ################################################
   // One beat link register
   // ################################################

   assign take = tx_beat.access && !full_q;             // Only when empty
   assign fwd  = full_q && strobe && !rx_wait;          // Release on strobe

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full_q <= 1'b0;
      end else if (take) begin
         full_q <= 1'b1;
      end else if (fwd) begin
         full_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) data_q <= tx_beat.data;
   end

   assign link_wait = full_q;
   assign rx_beat   = '{access: fwd, data: data_q};

   // Beats leave only on a strobe and never into a held receiver
   a_strobe_only : assert property (
      @(posedge clk) disable iff (!rst_n)
      rx_beat.access |-> (strobe && !rx_wait)
   );

endmodule

/* source/mio_tx_serializer.sv */
`timescale 1ns/1ps

module mio_tx_serializer (
   input  logic                  clk,
   input  logic                  rst_n,
   // Core side
   input  logic                  access_in,
   input  mio_pkg::emesh_packet_t packet_in,
   output logic                  wait_out,
   // Link side
   output mio_pkg::link_beat_t   tx_beat,
   input  logic                  link_wait
);

   import mio_pkg::*;

   // ################################################
   // State
   // ################################################

   logic [pw-1:0] shift_q;   // Unsent bytes, next one lowest
   logic [cw-1:0] cnt_q;     // Beats sent so far
   logic          busy_q;    // Packet still held

   logic accept;
   logic take;
   logic last;

   assign accept = access_in && !busy_q;
   assign take   = tx_beat.access && !link_wait;        // Pacer takes beat
   assign last   = (cnt_q == cw'(nbeats - 1));

   // ################################################
   // Control
   // ################################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
      end else begin
         if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
         end else if (take) begin
            cnt_q <= cnt_q + 1'b1;
            if (last) begin
               busy_q <= 1'b0;                          // Free after final beat
               cnt_q  <= '0;
            end
         end
      end
   end

   // Payload shifter, lowest byte goes out first
   always_ff @(posedge clk) begin
      if (accept) begin
         shift_q <= packet_in;
      end else if (take) begin
         shift_q <= shift_q >> miow;
      end
   end

   // Outputs
   assign wait_out = busy_q;
   assign tx_beat  = '{access: busy_q, data: shift_q[miow-1:0]};

   // Beat count bounded by packet length
   a_cnt_range : assert property (
      @(posedge clk) disable iff (!rst_n)
      cnt_q <= cw'(nbeats)
   );

endmodule

/* source/mio_pkg.sv */
package mio_pkg;

   // ################################################
   // Widths and counts
   // ################################################

   localparam int aw     = 32;            // Address width
   localparam int pw     = 2 * aw + 40;   // Mesh packet width
   localparam int miow   = 8;             // Link beat width
   localparam int nbeats = pw / miow;     // Beats per packet
   localparam int cw     = $clog2(nbeats + 1);

   // IO strobe once every io_div clocks
   localparam int io_div = 2;
   localparam int iow    = (io_div > 1) ? $clog2(io_div) : 1;

   // ################################################
   // Packet and beat types
   // ################################################

   // Listed MSB first so write lands on bit 0
   typedef struct packed {
      logic [aw-1:0] srcaddr;   // Bits 103 to 72
      logic [31:0]   data;      // Bits 71 to 40
      logic [aw-1:0] dstaddr;   // Bits 39 to 8
      logic [4:0]    ctrlmode;
      logic [1:0]    datamode;
      logic          write;     // Bit 0
   } emesh_packet_t;

   // One narrow transfer on the link
   typedef struct packed {
      logic            access;
      logic [miow-1:0] data;
   } link_beat_t;

endpackage
